/* bench/rx_buffer_model.sv */
// Receive buffer model
// Answers byte-address reads with random wait and 1 to 4 cycles of latency
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module rx_buffer_model (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_rd_en,
  input  nts_parser_pkg::byte_addr_t i_rd_addr,
  output logic                       o_rd_wait,
  output logic                       o_rd_dv,
  output logic [31:0]                o_rd_data
);

  // Frame bytes, written by the testbench
  logic [7:0]                 mem [0:(1 << `NTS_BYTE_ADDR_WIDTH) - 1];
  logic [15:0]                lfsr;
  logic                       busy;
  logic [2:0]                 cnt;
  nts_parser_pkg::byte_addr_t addr;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Fill with a pattern over all address bits
  initial begin
    for (int a = 0; a < (1 << `NTS_BYTE_ADDR_WIDTH); a++) begin
      mem[a] = 8'(a ^ (a >> 5));
    end
  end

  always @(posedge i_clk or posedge i_areset) begin : serve
    logic [15:0] r;
    logic [1:0]  b;
    if (i_areset) begin
      lfsr      <= 16'd7;
      o_rd_wait <= 1'b0;
      o_rd_dv   <= 1'b0;
      o_rd_data <= '0;
      busy      <= 1'b0;
      cnt       <= '0;
      addr      <= '0;
    end else begin
      r = lfsr;
      r = next_lfsr(r);
      b[1] = r[0];
      r = next_lfsr(r);
      b[0] = r[0];
      // Back-pressure about one cycle in four
      o_rd_wait <= &b;
      o_rd_dv   <= 1'b0;
      if (i_rd_en) begin
        r = next_lfsr(r);
        b[1] = r[0];
        r = next_lfsr(r);
        b[0] = r[0];
        busy <= 1'b1;
        cnt  <= {1'b0, b} + 3'd1;
        addr <= i_rd_addr;
      end else if (busy) begin
        if (cnt == 3'd1) begin
          o_rd_dv   <= 1'b1;
          o_rd_data <= {mem[addr], mem[addr + 1], mem[addr + 2], mem[addr + 3]};
          busy      <= 1'b0;
        end else begin
          cnt <= cnt - 3'd1;
        end
      end
      lfsr <= r;
    end
  end

endmodule

/* bench/tb_nts_parser.sv */
// NTS parser testbench
// Random frames from an LFSR, checked against a frame model
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module tb_nts_parser;

  logic                        i_clk;
  logic                        i_areset;
  logic                        i_clear;
  logic                        i_process;
  logic [7:0]                  i_last_word_data_valid;
  nts_parser_pkg::frame_word_u i_data;
  logic                        rd_wait;
  logic                        rd_dv;
  logic [31:0]                 rd_data;
  nts_parser_pkg::byte_addr_t  rd_addr;
  logic                        rd_en;
  logic [`NTS_EXT_BITS-1:0]    i_ext_sel;
  logic [15:0]                 o_ext_tag;
  logic [15:0]                 o_ext_length;
  nts_parser_pkg::byte_addr_t  o_ext_addr;
  logic [`NTS_EXT_BITS:0]      o_ext_count;
  logic                        o_busy;
  logic                        o_done;
  logic                        o_error;

  // Stimulus and model state
  logic [15:0]                 lfsr;
  logic [7:0]                  frame [0:1023];
  int                          flen;
  logic [7:0]                  mask;
  logic                        exp_error;
  int                          exp_count;
  logic [15:0]                 exp_tag [`NTS_EXT_FIELDS];
  logic [15:0]                 exp_len [`NTS_EXT_FIELDS];
  nts_parser_pkg::byte_addr_t  exp_adr [`NTS_EXT_FIELDS];

  nts_parser_top u_dut (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_clear                (i_clear),
    .i_process              (i_process),
    .i_last_word_data_valid (i_last_word_data_valid),
    .i_data                 (i_data),
    .i_rd_wait              (rd_wait),
    .i_rd_dv                (rd_dv),
    .i_rd_data              (rd_data),
    .o_rd_addr              (rd_addr),
    .o_rd_en                (rd_en),
    .i_ext_sel              (i_ext_sel),
    .o_ext_tag              (o_ext_tag),
    .o_ext_length           (o_ext_length),
    .o_ext_addr             (o_ext_addr),
    .o_ext_count            (o_ext_count),
    .o_busy                 (o_busy),
    .o_done                 (o_done),
    .o_error                (o_error)
  );

  rx_buffer_model u_buf (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_wait (rd_wait),
    .o_rd_dv   (rd_dv),
    .o_rd_data (rd_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // --------------------
  // Random numbers
  // --------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_outcome(input logic got_done, input logic got_error,
                               input logic exp_done, input logic exp_err);
    if (got_done !== exp_done || got_error !== exp_err) begin
      stop_run($sformatf("FAILED at %0t: done/error %b/%b, expected %b/%b",
                         $time, got_done, got_error, exp_done, exp_err));
    end
  endtask

  task automatic check_count(input logic [`NTS_EXT_BITS:0] got, input int exp);
    if (got !== (`NTS_EXT_BITS + 1)'(exp)) begin
      stop_run($sformatf("FAILED at %0t: extension count %0d, expected %0d",
                         $time, got, exp));
    end
  endtask

  task automatic check_ext_entry(input int idx, input logic [15:0] got_tag,
                                 input logic [15:0] got_len,
                                 input nts_parser_pkg::byte_addr_t got_adr);
    if (got_tag !== exp_tag[idx] || got_len !== exp_len[idx] ||
        got_adr !== exp_adr[idx]) begin
      stop_run($sformatf("FAILED at %0t: entry %0d is %h/%h/%0d, expected %h/%h/%0d",
                         $time, idx, got_tag, got_len, got_adr,
                         exp_tag[idx], exp_len[idx], exp_adr[idx]));
    end
  endtask

  // --------------------
  // Frame generator
  // --------------------
  // Kind 3 bad mask, 4 bad header, 5 bad extension, 6 too many extensions
  task automatic build_frame(input int kind);
    int          r;
    int          ihl;
    int          n_ext;
    int          total;
    int          a;
    int          ntp;
    int          bad_j;
    int          decl;
    int          lens [12];
    logic [15:0] ethertype;
    logic [3:0]  version;
    logic [15:0] udp_len;
    take_bits(2, r);
    ihl = 5 + r % 3;
    if (kind == 6) begin
      take_bits(1, r);
      n_ext = 9 + r;
    end else begin
      take_bits(3, r);
      n_ext = 1 + r % 7;
    end
    total = 0;
    for (int k = 0; k < n_ext; k++) begin
      take_bits(3, r);
      lens[k] = 4 * (r + 1);
      total += lens[k];
    end
    // Keep the UDP length at or above the minimum
    if (n_ext == 1 && lens[0] == 4) begin
      lens[0] = 8;
      total = 8;
    end
    ntp = 14 + ihl * 4 + 8 + 48;
    flen = ntp + total;
    for (int i = 0; i < flen; i++) begin
      take_bits(8, r);
      frame[i] = 8'(r);
    end
    ethertype = 16'h0800;
    version = 4'd4;
    udp_len = 16'(8 + 48 + total);
    if (kind == 4) begin
      take_bits(3, r);
      case (r % 5)
        0:       udp_len = 16'd60;
        1:       udp_len = 16'd65508;
        2:       udp_len = udp_len + 16'd2;
        3:       ethertype = 16'h86dd;
        default: version = 4'd6;
      endcase
    end
    frame[12] = ethertype[15:8];
    frame[13] = ethertype[7:0];
    frame[14] = {version, 4'(ihl)};
    frame[14 + ihl * 4 + 4] = udp_len[15:8];
    frame[14 + ihl * 4 + 5] = udp_len[7:0];
    // Extension length fields, tags stay random
    a = ntp;
    for (int k = 0; k < n_ext; k++) begin
      frame[a + 2] = 8'(lens[k] >> 8);
      frame[a + 3] = 8'(lens[k]);
      a += lens[k];
    end
    if (kind == 5) begin
      take_bits(3, r);
      bad_j = r % n_ext;
      a = ntp;
      for (int k = 0; k < bad_j; k++) begin
        a += lens[k];
      end
      take_bits(1, r);
      decl = (r != 0) ? lens[bad_j] + 2 : flen - a + 4;
      frame[a + 2] = 8'(decl >> 8);
      frame[a + 3] = 8'(decl);
    end
    mask = (flen % 8 == 0) ? 8'hff : 8'((1 << (flen % 8)) - 1);
    if (kind == 3) begin
      take_bits(1, r);
      mask = (r != 0) ? 8'h05 : 8'h3d;
    end
    for (int i = 0; i < flen; i++) begin
      u_buf.mem[i] = frame[i];
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  task automatic predict_frame();
    int          m;
    int          ihl;
    int          ntp;
    int          a;
    int          len;
    logic [15:0] udp;
    exp_error = 1'b1;
    exp_count = 0;
    m = int'(mask);
    if (m == 0 || (m & (m + 1)) != 0) return;
    ihl = int'(frame[14][3:0]);
    if ({frame[12], frame[13]} != 16'h0800 || frame[14][7:4] != 4'd4 || ihl < 5) return;
    udp = {frame[14 + ihl * 4 + 4], frame[14 + ihl * 4 + 5]};
    ntp = 14 + ihl * 4 + 8 + 48;
    if (udp < 64 || udp > 65507 || udp % 4 != 0 || ntp + 4 > flen) return;
    a = ntp;
    for (int k = 0; k < `NTS_EXT_FIELDS; k++) begin
      exp_tag[k] = {frame[a], frame[a + 1]};
      exp_len[k] = {frame[a + 2], frame[a + 3]};
      exp_adr[k] = nts_parser_pkg::byte_addr_t'(a);
      exp_count = k + 1;
      len = int'(exp_len[k]);
      if (len % 4 != 0 || a + len > flen) return;
      if (a + len == flen) begin
        exp_error = 1'b0;
        return;
      end
      a += len;
    end
  endtask

  // --------------------
  // Drivers and waits
  // --------------------
  task automatic send_frame(input logic check_mask_timing);
    nts_parser_pkg::frame_word_u w;
    int                          n_words;
    n_words = (flen + 7) / 8;
    for (int k = 0; k < n_words; k++) begin
      for (int b = 0; b < 8; b++) begin
        w.bytes[b] = (8 * k + b < flen) ? frame[8 * k + b] : 8'h00;
      end
      @(posedge i_clk);
      i_process <= 1'b1;
      i_data <= w;
      i_last_word_data_valid <= mask;
      @(negedge i_clk);
      // Bad mask error lands exactly 2 cycles after the first word
      if (check_mask_timing && k <= 2) begin
        check_outcome(o_done, o_error, 1'b0, k == 2);
      end
    end
    @(posedge i_clk);
    i_process <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge i_clk);
    i_clear <= 1'b1;
    @(posedge i_clk);
    i_clear <= 1'b0;
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_done && !o_error) begin
      n++;
      if (n > 3000) stop_run("Timeout while waiting for a done or error pulse");
      @(negedge i_clk);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge i_clk);
    while (o_busy) begin
      n++;
      if (n > 100) stop_run("Timeout while waiting for the parser to go idle");
      @(negedge i_clk);
    end
  endtask

  task automatic wait_read();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!rd_en) begin
      n++;
      if (n > 200) stop_run("Timeout while waiting for the first buffer read");
      @(negedge i_clk);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int kind;
    lfsr = 16'd7;
    i_areset = 1'b1;
    i_clear = 1'b0;
    i_process = 1'b0;
    i_last_word_data_valid = 8'h00;
    i_data = '0;
    i_ext_sel = '0;
    repeat (8) @(posedge i_clk);
    i_areset <= 1'b0;
    for (int f = 0; f < 64; f++) begin
      kind = f % 8;
      pulse_clear();
      build_frame(kind);
      predict_frame();
      if (kind == 3) begin
        send_frame(1'b1);
        wait_idle();
        check_count(o_ext_count, 0);
      end else if (kind == 7) begin
        // Abort in the middle of a walk
        send_frame(1'b0);
        wait_read();
        pulse_clear();
        repeat (20) begin
          @(negedge i_clk);
          check_outcome(o_done, o_error, 1'b0, 1'b0);
        end
        if (o_busy) stop_run($sformatf("FAILED at %0t: busy after clear", $time));
        check_count(o_ext_count, 0);
      end else begin
        send_frame(1'b0);
        wait_result();
        check_outcome(o_done, o_error, !exp_error, exp_error);
        check_count(o_ext_count, exp_count);
        for (int i = 0; i < exp_count; i++) begin
          @(posedge i_clk);
          i_ext_sel <= `NTS_EXT_BITS'(i);
          @(negedge i_clk);
          check_ext_entry(i, o_ext_tag, o_ext_length, o_ext_addr);
        end
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* include/nts_parser_consts.svh */
// NTS parser constants
// Widths, FSM state codes, UDP length limits and frame offsets
`ifndef NTS_PARSER_CONSTS_SVH
`define NTS_PARSER_CONSTS_SVH

// --------------------
// Widths
// --------------------
// Word address into the receive buffer
`define NTS_ADDR_WIDTH 10
// Byte address, three more bits for the byte lane
`define NTS_BYTE_ADDR_WIDTH (`NTS_ADDR_WIDTH + 3)

// Extension table size
`define NTS_EXT_BITS 3
`define NTS_EXT_FIELDS 8

// --------------------
// Control FSM states
// --------------------
`define NTS_ST_IDLE          4'h0
`define NTS_ST_COPY          4'h1
`define NTS_ST_EXTRACT       4'h2
`define NTS_ST_LENGTH_CHECKS 4'h3
`define NTS_ST_WALK          4'h4
`define NTS_ST_DONE          4'h5
`define NTS_ST_ERROR         4'hf

// UDP header + minimum NTP payload + smallest extension
`define NTS_UDP_LEN_MIN 64
// Largest UDP payload over IPv4
`define NTS_UDP_LEN_MAX 65507

// --------------------
// Frame layout
// --------------------
`define NTS_ETHERTYPE_IPV4 16'h0800
`define NTS_ETH_HDR_BYTES  14
`define NTS_UDP_HDR_BYTES  8
`define NTS_NTP_HDR_BYTES  48

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the NTS parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_nts_parser \
  -f sim.f -o tb_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim.f */
+incdir+include
verilog/nts_parser_pkg.sv
verilog/frame_byte_counter.sv
verilog/ip_field_capture.sv
verilog/parser_ctrl_fsm.sv
verilog/extension_walker.sv
verilog/nts_parser_top.sv
bench/rx_buffer_model.sv
bench/tb_nts_parser.sv

/* verilog/extension_walker.sv */
// NTP extension walker
// Reads tag/length words over the buffer port and fills the extension table
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module extension_walker (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_clear,
  input  logic                       i_walk_start,
  input  nts_parser_pkg::byte_addr_t i_ntp_addr,
  input  nts_parser_pkg::byte_addr_t i_mem_bound,
  // Receive buffer read port
  input  logic                       i_rd_wait,
  input  logic                       i_rd_dv,
  input  logic [31:0]                i_rd_data,
  output nts_parser_pkg::byte_addr_t o_rd_addr,
  output logic                       o_rd_en,
  // Walk result
  output logic                       o_walk_done,
  output logic                       o_walk_fail,
  // Table readout
  input  logic [`NTS_EXT_BITS-1:0]   i_ext_sel,
  output logic [15:0]                o_ext_tag,
  output logic [15:0]                o_ext_length,
  output nts_parser_pkg::byte_addr_t o_ext_addr,
  output logic [`NTS_EXT_BITS:0]     o_ext_count
);

  logic                       active;
  logic                       pending;
  logic                       issue;
  logic                       store;
  nts_parser_pkg::byte_addr_t cur_addr;
  logic [`NTS_EXT_BITS-1:0]   slot;
  logic [16:0]                next_addr;
  logic                       len_bad;
  logic                       past_end;
  logic                       at_end;
  logic                       table_full;

  // Extension table
  logic [15:0]                ext_tag [`NTS_EXT_FIELDS];
  logic [15:0]                ext_len [`NTS_EXT_FIELDS];
  nts_parser_pkg::byte_addr_t ext_adr [`NTS_EXT_FIELDS];

  // One outstanding read at a time
  assign issue = active && !pending && !i_rd_wait;
  assign store = active && pending && i_rd_dv;
  assign slot  = o_ext_count[`NTS_EXT_BITS-1:0];

  // --------------------
  // Next entry address
  // --------------------
  // Tag is the upper half of the read word, length the lower half
  assign next_addr  = {{(17 - `NTS_BYTE_ADDR_WIDTH){1'b0}}, cur_addr} +
                      {1'b0, i_rd_data[15:0]};
  // Extensions are zero padded to 4 byte boundaries
  assign len_bad    = (i_rd_data[1:0] != 2'b00);
  assign past_end   = next_addr > {{(17 - `NTS_BYTE_ADDR_WIDTH){1'b0}}, i_mem_bound};
  assign at_end     = next_addr == {{(17 - `NTS_BYTE_ADDR_WIDTH){1'b0}}, i_mem_bound};
  assign table_full = (slot == `NTS_EXT_BITS'(`NTS_EXT_FIELDS - 1));

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      active      <= 1'b0;
      pending     <= 1'b0;
      o_rd_en     <= 1'b0;
      o_rd_addr   <= '0;
      cur_addr    <= '0;
      o_ext_count <= '0;
      o_walk_done <= 1'b0;
      o_walk_fail <= 1'b0;
    end else if (i_clear) begin
      active      <= 1'b0;
      pending     <= 1'b0;
      o_rd_en     <= 1'b0;
      o_ext_count <= '0;
      o_walk_done <= 1'b0;
      o_walk_fail <= 1'b0;
    end else begin
      // Read enable and result flags are single-cycle pulses
      o_rd_en     <= issue;
      o_walk_done <= 1'b0;
      o_walk_fail <= 1'b0;
      if (i_walk_start) begin
        active      <= 1'b1;
        pending     <= 1'b0;
        cur_addr    <= i_ntp_addr;
        o_ext_count <= '0;
      end else if (issue) begin
        pending   <= 1'b1;
        o_rd_addr <= cur_addr;
      end else if (store) begin
        pending     <= 1'b0;
        o_ext_count <= o_ext_count + 1'b1;
        if (len_bad || past_end) begin
          active      <= 1'b0;
          o_walk_fail <= 1'b1;
        end else if (at_end) begin
          active      <= 1'b0;
          o_walk_done <= 1'b1;
        end else if (table_full) begin
          // Eighth entry stored and the chain still goes on
          active      <= 1'b0;
          o_walk_fail <= 1'b1;
        end else begin
          cur_addr <= next_addr[`NTS_BYTE_ADDR_WIDTH-1:0];
        end
      end
    end
  end

  // --------------------
  // Table storage
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_clear || i_walk_start) begin
      for (int i = 0; i < `NTS_EXT_FIELDS; i++) begin
        ext_tag[i] <= '0;
        ext_len[i] <= '0;
        ext_adr[i] <= '0;
      end
    end else if (store) begin
      ext_tag[slot] <= i_rd_data[31:16];
      ext_len[slot] <= i_rd_data[15:0];
      ext_adr[slot] <= cur_addr;
    end
  end

  assign o_ext_tag    = ext_tag[i_ext_sel];
  assign o_ext_length = ext_len[i_ext_sel];
  assign o_ext_addr   = ext_adr[i_ext_sel];

endmodule

/* verilog/frame_byte_counter.sv */
// Frame byte counter
// Counts burst words and forms the exact byte bound of the frame
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module frame_byte_counter (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_clear,
  input  logic                       i_process,
  input  logic [7:0]                 i_last_word_data_valid,
  output nts_parser_pkg::byte_addr_t o_mem_bound,
  output logic                       o_mask_bad
);

  logic                       proc_q;
  logic [`NTS_ADDR_WIDTH-1:0] word_cnt;
  logic [3:0]                 last_bytes;
  logic [3:0]                 mask_bytes;
  logic                       first_word;
  logic                       burst_end;

  // Burst edges
  assign first_word = i_process & ~proc_q;
  assign burst_end  = proc_q & ~i_process;

  // Mask must be low-aligned and contiguous, zero flags a bad mask
  always_comb begin
    case (i_last_word_data_valid)
      8'b0000_0001: mask_bytes = 4'd1;
      8'b0000_0011: mask_bytes = 4'd2;
      8'b0000_0111: mask_bytes = 4'd3;
      8'b0000_1111: mask_bytes = 4'd4;
      8'b0001_1111: mask_bytes = 4'd5;
      8'b0011_1111: mask_bytes = 4'd6;
      8'b0111_1111: mask_bytes = 4'd7;
      8'b1111_1111: mask_bytes = 4'd8;
      default:      mask_bytes = 4'd0;
    endcase
  end

  // --------------------
  // Word count and bound
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      proc_q      <= 1'b0;
      word_cnt    <= '0;
      o_mask_bad  <= 1'b0;
      o_mem_bound <= '0;
    end else if (i_clear) begin
      proc_q      <= 1'b0;
      word_cnt    <= '0;
      o_mask_bad  <= 1'b0;
      o_mem_bound <= '0;
    end else begin
      proc_q <= i_process;
      // word_cnt holds N-1 at the end of the burst
      if (first_word) begin
        word_cnt   <= '0;
        o_mask_bad <= (mask_bytes == 4'd0);
      end else if (i_process) begin
        word_cnt <= word_cnt + 1'b1;
      end
      // Full words times 8 plus the bytes of the last word
      if (burst_end) begin
        o_mem_bound <= {word_cnt, 3'b000} +
                       {{(`NTS_BYTE_ADDR_WIDTH - 4){1'b0}}, last_bytes};
      end
    end
  end

  // Last-word byte count, taken in the first burst cycle
  always_ff @(posedge i_clk) begin
    if (first_word) begin
      last_bytes <= mask_bytes;
    end
  end

endmodule

/* verilog/ip_field_capture.sv */
// IP field capture
// Picks ethertype, version/IHL and UDP length out of the word stream
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module ip_field_capture (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_clear,
  input  logic                        i_process,
  input  nts_parser_pkg::frame_word_u i_data,
  output logic                        o_is_ipv4,
  output nts_parser_pkg::byte_addr_t  o_ntp_addr,
  output logic [15:0]                 o_udp_length
);

  logic                       proc_q;
  logic [`NTS_ADDR_WIDTH-1:0] next_idx;
  logic [`NTS_ADDR_WIDTH-1:0] word_idx;
  logic                       first_word;
  logic [15:0]                ethertype;
  logic [7:0]                 ver_ihl;
  nts_parser_pkg::byte_addr_t ihl_bytes;
  nts_parser_pkg::byte_addr_t udp_len_pos;

  assign first_word = i_process & ~proc_q;

  // Index of the word on i_data in this cycle
  assign word_idx = first_word ? '0 : next_idx;

  // --------------------
  // Header offsets
  // --------------------
  // IP header length in bytes, IHL counts 32-bit words
  assign ihl_bytes = {{(`NTS_BYTE_ADDR_WIDTH - 6){1'b0}}, ver_ihl[3:0], 2'b00};

  // UDP length sits 4 bytes into the UDP header
  assign udp_len_pos = ihl_bytes +
                       nts_parser_pkg::byte_addr_t'(`NTS_ETH_HDR_BYTES + 4);

  // Extensions start after UDP header and fixed NTP header
  assign o_ntp_addr = ihl_bytes + nts_parser_pkg::byte_addr_t'(
                      `NTS_ETH_HDR_BYTES + `NTS_UDP_HDR_BYTES + `NTS_NTP_HDR_BYTES);

  // IPv4 needs the ethertype, version 4 and at least 5 header words
  assign o_is_ipv4 = (ethertype == `NTS_ETHERTYPE_IPV4) &&
                     (ver_ihl[7:4] == 4'd4) && (ver_ihl[3:0] >= 4'd5);

  // Word index tracking
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      proc_q   <= 1'b0;
      next_idx <= '0;
    end else if (i_clear) begin
      proc_q   <= 1'b0;
      next_idx <= '0;
    end else begin
      proc_q <= i_process;
      if (i_process) begin
        next_idx <= word_idx + 1'b1;
      end
    end
  end

  // --------------------
  // Field capture
  // --------------------
  always_ff @(posedge i_clk) begin
    if (first_word) begin
      // Fresh frame, stale fields must not pass the checks
      ethertype    <= '0;
      ver_ihl      <= '0;
      o_udp_length <= '0;
    end else if (i_process) begin
      // Word 1 holds bytes 8..15: ethertype at 12, version/IHL at 14
      if (word_idx == `NTS_ADDR_WIDTH'(1)) begin
        ethertype <= i_data.halves[2];
        ver_ihl   <= i_data.bytes[6];
      end
      // UDP length is always halfword aligned
      if (word_idx == udp_len_pos[`NTS_BYTE_ADDR_WIDTH-1:3]) begin
        o_udp_length <= i_data.halves[udp_len_pos[2:1]];
      end
    end
  end

endmodule

/* verilog/nts_parser_pkg.sv */
// NTS parser types
// Frame word views and the byte address type shared by the blocks
`include "nts_parser_consts.svh"

package nts_parser_pkg;

  // One 64-bit frame word, big-endian
  // Byte 0 and halfword 0 sit in the top bits
  typedef union packed {
    logic [0:7][7:0]  bytes;
    logic [0:3][15:0] halves;
  } frame_word_u;

  // Byte address into the frame
  typedef logic [`NTS_BYTE_ADDR_WIDTH-1:0] byte_addr_t;

endpackage

/* verilog/nts_parser_top.sv */
// NTS parser top
// Byte counting, IP field capture, control FSM and extension walk
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module nts_parser_top (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_clear,
  // Frame stream
  input  logic                        i_process,
  input  logic [7:0]                  i_last_word_data_valid,
  input  nts_parser_pkg::frame_word_u i_data,
  // Receive buffer read port
  input  logic                        i_rd_wait,
  input  logic                        i_rd_dv,
  input  logic [31:0]                 i_rd_data,
  output nts_parser_pkg::byte_addr_t  o_rd_addr,
  output logic                        o_rd_en,
  // Extension table readout
  input  logic [`NTS_EXT_BITS-1:0]    i_ext_sel,
  output logic [15:0]                 o_ext_tag,
  output logic [15:0]                 o_ext_length,
  output nts_parser_pkg::byte_addr_t  o_ext_addr,
  output logic [`NTS_EXT_BITS:0]      o_ext_count,
  // Status
  output logic                        o_busy,
  output logic                        o_done,
  output logic                        o_error
);

  nts_parser_pkg::byte_addr_t mem_bound;
  nts_parser_pkg::byte_addr_t ntp_addr;
  logic                       mask_bad;
  logic                       is_ipv4;
  logic [15:0]                udp_length;
  logic                       walk_start;
  logic                       walk_done;
  logic                       walk_fail;

  frame_byte_counter u_counter (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_clear                (i_clear),
    .i_process              (i_process),
    .i_last_word_data_valid (i_last_word_data_valid),
    .o_mem_bound            (mem_bound),
    .o_mask_bad             (mask_bad)
  );

  ip_field_capture u_capture (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_clear      (i_clear),
    .i_process    (i_process),
    .i_data       (i_data),
    .o_is_ipv4    (is_ipv4),
    .o_ntp_addr   (ntp_addr),
    .o_udp_length (udp_length)
  );

  parser_ctrl_fsm u_fsm (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_clear      (i_clear),
    .i_process    (i_process),
    .i_mask_bad   (mask_bad),
    .i_is_ipv4    (is_ipv4),
    .i_udp_length (udp_length),
    .i_ntp_addr   (ntp_addr),
    .i_mem_bound  (mem_bound),
    .i_walk_done  (walk_done),
    .i_walk_fail  (walk_fail),
    .o_walk_start (walk_start),
    .o_busy       (o_busy),
    .o_done       (o_done),
    .o_error      (o_error)
  );

  extension_walker u_walker (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_clear      (i_clear),
    .i_walk_start (walk_start),
    .i_ntp_addr   (ntp_addr),
    .i_mem_bound  (mem_bound),
    .i_rd_wait    (i_rd_wait),
    .i_rd_dv      (i_rd_dv),
    .i_rd_data    (i_rd_data),
    .i_ext_sel    (i_ext_sel),
    .o_rd_addr    (o_rd_addr),
    .o_rd_en      (o_rd_en),
    .o_walk_done  (walk_done),
    .o_walk_fail  (walk_fail),
    .o_ext_tag    (o_ext_tag),
    .o_ext_length (o_ext_length),
    .o_ext_addr   (o_ext_addr),
    .o_ext_count  (o_ext_count)
  );

endmodule

/* verilog/parser_ctrl_fsm.sv */
// Parser control FSM
// Sequences copy, field extract, UDP length checks and the extension walk
`timescale 1ns/10ps
`include "nts_parser_consts.svh"

module parser_ctrl_fsm (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_clear,
  input  logic                       i_process,
  input  logic                       i_mask_bad,
  input  logic                       i_is_ipv4,
  input  logic [15:0]                i_udp_length,
  input  nts_parser_pkg::byte_addr_t i_ntp_addr,
  input  nts_parser_pkg::byte_addr_t i_mem_bound,
  input  logic                       i_walk_done,
  input  logic                       i_walk_fail,
  output logic                       o_walk_start,
  output logic                       o_busy,
  output logic                       o_done,
  output logic                       o_error
);

  logic [3:0]                   state;
  logic [3:0]                   state_next;
  logic                         proc_q;
  logic                         checks_fail;
  logic [`NTS_BYTE_ADDR_WIDTH:0] ntp_end;

  // --------------------
  // Length checks
  // --------------------
  // One spare bit so the first tag/length word cannot wrap
  assign ntp_end = {1'b0, i_ntp_addr} + (`NTS_BYTE_ADDR_WIDTH + 1)'(4);

  assign checks_fail = !i_is_ipv4 ||
                       (i_udp_length < 16'(`NTS_UDP_LEN_MIN)) ||
                       (i_udp_length > 16'(`NTS_UDP_LEN_MAX)) ||
                       // NTP packets always end on a 4 byte boundary
                       (i_udp_length[1:0] != 2'b00) ||
                       (ntp_end > {1'b0, i_mem_bound});

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      `NTS_ST_IDLE: begin
        // Start only on a rising i_process, never mid-burst
        if (i_process && !proc_q) begin
          state_next = `NTS_ST_COPY;
        end
      end
      `NTS_ST_COPY: begin
        // Bad mask aborts at once, 2 cycles after the burst starts
        if (i_mask_bad) begin
          state_next = `NTS_ST_ERROR;
        end else if (!i_process) begin
          state_next = `NTS_ST_EXTRACT;
        end
      end
      // Bound and fields settle here
      `NTS_ST_EXTRACT:       state_next = `NTS_ST_LENGTH_CHECKS;
      `NTS_ST_LENGTH_CHECKS: state_next = checks_fail ? `NTS_ST_ERROR : `NTS_ST_WALK;
      `NTS_ST_WALK: begin
        if (i_walk_fail) begin
          state_next = `NTS_ST_ERROR;
        end else if (i_walk_done) begin
          state_next = `NTS_ST_DONE;
        end
      end
      default: state_next = `NTS_ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state  <= `NTS_ST_IDLE;
      proc_q <= 1'b0;
    end else if (i_clear) begin
      state  <= `NTS_ST_IDLE;
      proc_q <= 1'b0;
    end else begin
      state  <= state_next;
      proc_q <= i_process;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  // DONE, ERROR and LENGTH_CHECKS last one cycle, so these are pulses
  assign o_walk_start = (state == `NTS_ST_LENGTH_CHECKS) && !checks_fail;
  assign o_busy       = (state != `NTS_ST_IDLE);
  assign o_done       = (state == `NTS_ST_DONE);
  assign o_error      = (state == `NTS_ST_ERROR);

endmodule
